// ==== trellisPkg.sv ====
// trellis definitions for the 20-state detector
// state geometry, predecessor steps and metric widths
package trellisPkg;

   // ----------------------------------------
   // trellis geometry
   // ----------------------------------------
   localparam int numStates  = 20;
   localparam int stateWidth = 5;

   // state j is entered from state (j+zeroStep) on the zero branch
   // and from state (j+oneStep) on the one branch, both mod numStates
   localparam int zeroStep = 13;
   localparam int oneStep  = 7;

   // ----------------------------------------
   // metric widths
   // ----------------------------------------
   // one branch metric, a distance
   localparam int branchWidth = 8;

   // accumulated metric with four guard bits
   localparam int pathWidth = branchWidth + 4;

   // full scale of a path metric
   localparam logic [pathWidth-1:0] pathMax = {pathWidth{1'b1}};

endpackage

// ==== survivorPkg.sv ====
// survivor storage definitions
// memory sizing, port requesters and traceback FSM states
package survivorPkg;

   // ----------------------------------------
   // survivor memory
   // ----------------------------------------
   // entries walked back for each decision
   localparam int tracebackDepth = 16;

   localparam int memDepth  = 32;
   localparam int addrWidth = 5;

   // users of the single memory port
   typedef enum logic [1:0] {
      reqNone,
      reqWrite,
      reqRead
   } requester;

   // ----------------------------------------
   // traceback FSM
   // ----------------------------------------
   typedef enum logic [1:0] {
      tbIdle,
      tbRead,
      tbWait,
      tbEmit
   } tbState;

endpackage

// ==== acsArray.sv ====
// add-compare-select array of the 20-state trellis
// updates renormalised, saturated path metrics on each symbol strobe
// and requests a write of the survivor vector one cycle later
module acsArray (
   input  logic                                                    clk,
   input  logic                                                    reset,
   input  logic                                                    symEn,
   input  logic [trellisPkg::numStates*trellisPkg::branchWidth-1:0] zeroMetrics,
   input  logic [trellisPkg::numStates*trellisPkg::branchWidth-1:0] oneMetrics,
   input  logic [trellisPkg::pathWidth-1:0]                        bestMetric,
   output logic [trellisPkg::numStates*trellisPkg::pathWidth-1:0]  pathMetrics,
   output logic                                                    acsValid,
   output logic                                                    writeReq,
   output logic [survivorPkg::addrWidth-1:0]                       writeAddr,
   output logic [trellisPkg::numStates-1:0]                        writeData
);

   logic [trellisPkg::pathWidth-1:0]   metric     [trellisPkg::numStates];
   logic [trellisPkg::pathWidth-1:0]   nextMetric [trellisPkg::numStates];
   logic [trellisPkg::branchWidth-1:0] zeroBranch [trellisPkg::numStates];
   logic [trellisPkg::branchWidth-1:0] oneBranch  [trellisPkg::numStates];
   logic [trellisPkg::numStates-1:0]   survivor;

   // ----------------------------------------
   // one ACS unit per state
   // ----------------------------------------
   genvar j;
   generate
      for (j = 0; j < trellisPkg::numStates; j++) begin : gAcs
         logic [trellisPkg::pathWidth:0] sumZero;
         logic [trellisPkg::pathWidth:0] sumOne;
         logic [trellisPkg::pathWidth:0] chosen;
         logic [trellisPkg::pathWidth:0] renorm;

         // unpack the branch metrics of source state j
         assign zeroBranch[j] = zeroMetrics[j*trellisPkg::branchWidth +: trellisPkg::branchWidth];
         assign oneBranch[j]  = oneMetrics[j*trellisPkg::branchWidth +: trellisPkg::branchWidth];
         assign pathMetrics[j*trellisPkg::pathWidth +: trellisPkg::pathWidth] = metric[j];

         // add
         assign sumZero = metric[(j + trellisPkg::zeroStep) % trellisPkg::numStates]
                        + zeroBranch[(j + trellisPkg::zeroStep) % trellisPkg::numStates];
         assign sumOne  = metric[(j + trellisPkg::oneStep) % trellisPkg::numStates]
                        + oneBranch[(j + trellisPkg::oneStep) % trellisPkg::numStates];

         // compare and select, a tie keeps the zero branch
         assign survivor[j] = sumOne < sumZero;
         assign chosen      = survivor[j] ? sumOne : sumZero;

         // the sources are never below last symbol's best metric
         assign renorm        = chosen - bestMetric;
         assign nextMetric[j] = (renorm > trellisPkg::pathMax) ?
                                trellisPkg::pathMax : renorm[trellisPkg::pathWidth-1:0];
      end
   endgenerate

   // ----------------------------------------
   // metric registers and write pointer
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < trellisPkg::numStates; s++) begin
            metric[s] <= '0;
         end
         acsValid  <= 1'b0;
         writeAddr <= '0;
      end else begin
         acsValid <= symEn;
         if (symEn) begin
            for (int s = 0; s < trellisPkg::numStates; s++) begin
               metric[s] <= nextMetric[s];
            end
            // advance to the slot of this symbol, it stays the newest entry afterwards
            if (writeAddr == survivorPkg::addrWidth'(survivorPkg::memDepth - 1)) begin
               writeAddr <= '0;
            end else begin
               writeAddr <= writeAddr + 1'b1;
            end
         end
      end
   end

   // survivor vector of the current symbol
   always_ff @(posedge clk) begin
      if (symEn) begin
         writeData <= survivor;
      end
   end

   // the writer has port priority, so one request cycle is enough
   assign writeReq = acsValid;

endmodule

// ==== bestStateFinder.sv ====
// best state search over all path metrics
// registers the smallest metric and its state, lowest index on a tie
module bestStateFinder (
   input  logic                                                   clk,
   input  logic                                                   reset,
   input  logic                                                   acsValid,
   input  logic [trellisPkg::numStates*trellisPkg::pathWidth-1:0] pathMetrics,
   output logic                                                   bestValid,
   output logic [trellisPkg::stateWidth-1:0]                      bestState,
   output logic [trellisPkg::pathWidth-1:0]                       bestMetric
);

   logic [trellisPkg::pathWidth-1:0]  minMetric;
   logic [trellisPkg::stateWidth-1:0] minState;

   // linear scan, strict compare keeps the lowest index
   always_comb begin
      minMetric = pathMetrics[0 +: trellisPkg::pathWidth];
      minState  = '0;
      for (int s = 1; s < trellisPkg::numStates; s++) begin
         if (pathMetrics[s*trellisPkg::pathWidth +: trellisPkg::pathWidth] < minMetric) begin
            minMetric = pathMetrics[s*trellisPkg::pathWidth +: trellisPkg::pathWidth];
            minState  = trellisPkg::stateWidth'(s);
         end
      end
   end

   // result is held until the next symbol
   always_ff @(posedge clk) begin
      if (reset) begin
         bestValid  <= 1'b0;
         bestState  <= '0;
         bestMetric <= '0;
      end else begin
         bestValid <= acsValid;
         if (acsValid) begin
            bestState  <= minState;
            bestMetric <= minMetric;
         end
      end
   end

endmodule

// ==== memoryArbiter.sv ====
// survivor memory port arbiter
// the ACS writer has fixed priority over the traceback reader
module memoryArbiter (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              writeReq,
   input  logic                              readReq,
   input  logic [survivorPkg::addrWidth-1:0] writeAddr,
   input  logic [survivorPkg::addrWidth-1:0] readAddr,
   input  logic [trellisPkg::numStates-1:0]  writeData,
   output logic                              writeGrant,
   output logic                              readGrant,
   output logic                              memWrite,
   output logic [survivorPkg::addrWidth-1:0] memAddr,
   output logic [trellisPkg::numStates-1:0]  memWriteData
);

   survivorPkg::requester grant;
   survivorPkg::requester lastGrant;

   always_comb begin
      if (writeReq) begin
         grant = survivorPkg::reqWrite;
      end else if (readReq) begin
         grant = survivorPkg::reqRead;
      end else begin
         grant = survivorPkg::reqNone;
      end
   end

   assign writeGrant   = (grant == survivorPkg::reqWrite);
   assign readGrant    = (grant == survivorPkg::reqRead);
   assign memWrite     = writeGrant;
   assign memWriteData = writeData;

   // port steering, an idle port stays on the address of its last user
   always_comb begin
      case (grant)
         survivorPkg::reqWrite: memAddr = writeAddr;
         survivorPkg::reqRead:  memAddr = readAddr;
         default:               memAddr = (lastGrant == survivorPkg::reqRead) ? readAddr : writeAddr;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         lastGrant <= survivorPkg::reqNone;
      end else if (grant != survivorPkg::reqNone) begin
         lastGrant <= grant;
      end
   end

endmodule

// ==== survivorMemory.sv ====
// single-port survivor decision RAM
// one survivor vector per symbol, registered read data
module survivorMemory #(
   parameter int dataWidth = 32
) (
   input  logic                              clk,
   input  logic                              memWrite,
   input  logic [survivorPkg::addrWidth-1:0] memAddr,
   input  logic [dataWidth-1:0]              memWriteData,
   output logic [dataWidth-1:0]              memReadData
);

   logic [dataWidth-1:0] mem [survivorPkg::memDepth];

   // read data appears the cycle after the access
   always_ff @(posedge clk) begin
      if (memWrite) begin
         mem[memAddr] <= memWriteData;
      end
      memReadData <= mem[memAddr];
   end

endmodule

// ==== traceBackUnit.sv ====
// traceback unit of the survivor history
// walks tracebackDepth entries back from the best state, newest first,
// and emits the survivor bit of the state reached at the oldest entry
module traceBackUnit (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              bestValid,
   input  logic [trellisPkg::stateWidth-1:0] bestState,
   input  logic [survivorPkg::addrWidth-1:0] headAddr,
   input  logic                              readGrant,
   input  logic [trellisPkg::numStates-1:0]  memReadData,
   output logic                              readReq,
   output logic [survivorPkg::addrWidth-1:0] readAddr,
   output logic                              decisionValid,
   output logic                              decision
);

   survivorPkg::tbState state;

   logic [$clog2(survivorPkg::tracebackDepth)-1:0] symCount;
   logic [$clog2(survivorPkg::tracebackDepth)-1:0] readCount;
   logic                                           warm;
   logic                                           start;
   logic                                           dataValid;
   logic [trellisPkg::stateWidth-1:0]              curState;
   logic                                           survivorBit;
   logic [trellisPkg::stateWidth:0]                step;
   logic [trellisPkg::stateWidth:0]                stepped;
   logic [trellisPkg::stateWidth:0]                wrapped;

   // a full history exists once tracebackDepth-1 symbols have gone by
   assign warm  = (symCount == survivorPkg::tracebackDepth - 1);
   assign start = (state == survivorPkg::tbIdle) && bestValid && warm;

   // ----------------------------------------
   // predecessor step
   // ----------------------------------------
   assign survivorBit = memReadData[curState];
   assign step        = survivorBit ? (trellisPkg::stateWidth + 1)'(trellisPkg::oneStep)
                                    : (trellisPkg::stateWidth + 1)'(trellisPkg::zeroStep);
   assign stepped     = {1'b0, curState} + step;
   assign wrapped     = (stepped >= trellisPkg::numStates) ?
                        stepped - (trellisPkg::stateWidth + 1)'(trellisPkg::numStates) : stepped;

   // ----------------------------------------
   // traceback FSM
   // ----------------------------------------
   // reads are issued back to back, the state walk follows one cycle behind
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= survivorPkg::tbIdle;
         symCount  <= '0;
         readCount <= '0;
         readAddr  <= '0;
         dataValid <= 1'b0;
      end else begin
         dataValid <= readReq && readGrant;
         if (bestValid && !warm) begin
            symCount <= symCount + 1'b1;
         end
         case (state)
            survivorPkg::tbIdle: begin
               if (start) begin
                  state     <= survivorPkg::tbRead;
                  readAddr  <= headAddr;
                  readCount <= '0;
               end
            end
            survivorPkg::tbRead: begin
               // a colliding write holds the request for a cycle
               if (readGrant) begin
                  readCount <= readCount + 1'b1;
                  if (readAddr == '0) begin
                     readAddr <= survivorPkg::addrWidth'(survivorPkg::memDepth - 1);
                  end else begin
                     readAddr <= readAddr - 1'b1;
                  end
                  if (readCount == survivorPkg::tracebackDepth - 1) begin
                     state <= survivorPkg::tbWait;
                  end
               end
            end
            survivorPkg::tbWait: begin
               // oldest entry arrives here
               if (dataValid) begin
                  state <= survivorPkg::tbEmit;
               end
            end
            default: begin
               state <= survivorPkg::tbIdle;
            end
         endcase
      end
   end

   // state walk and decision
   always_ff @(posedge clk) begin
      if (start) begin
         curState <= bestState;
      end else if (dataValid) begin
         curState <= wrapped[trellisPkg::stateWidth-1:0];
      end
      if (state == survivorPkg::tbWait && dataValid) begin
         decision <= survivorBit;
      end
   end

   assign readReq       = (state == survivorPkg::tbRead);
   assign decisionValid = (state == survivorPkg::tbEmit);

endmodule

// ==== viterbiDecoder.sv ====
// 20-state Viterbi detector top level
// ACS array, best state search, survivor memory with its arbiter
// and the traceback unit
module viterbiDecoder (
   input  logic                                                    clk,
   input  logic                                                    reset,
   input  logic                                                    symEn,
   input  logic [trellisPkg::numStates*trellisPkg::branchWidth-1:0] zeroMetrics,
   input  logic [trellisPkg::numStates*trellisPkg::branchWidth-1:0] oneMetrics,
   output logic                                                    bestValid,
   output logic [trellisPkg::stateWidth-1:0]                       bestState,
   output logic [trellisPkg::pathWidth-1:0]                        bestMetric,
   output logic                                                    decisionValid,
   output logic                                                    decision
);

   logic [trellisPkg::numStates*trellisPkg::pathWidth-1:0] pathMetrics;
   logic                                                   acsValid;
   logic                                                   writeReq;
   logic [survivorPkg::addrWidth-1:0]                      writeAddr;
   logic [trellisPkg::numStates-1:0]                       writeData;
   logic                                                   readReq;
   logic                                                   readGrant;
   logic [survivorPkg::addrWidth-1:0]                      readAddr;
   logic                                                   memWrite;
   logic [survivorPkg::addrWidth-1:0]                      memAddr;
   logic [trellisPkg::numStates-1:0]                       memWriteData;
   logic [trellisPkg::numStates-1:0]                       memReadData;

   acsArray acs0 (
      .clk(clk), .reset(reset), .symEn(symEn),
      .zeroMetrics(zeroMetrics), .oneMetrics(oneMetrics),
      .bestMetric(bestMetric), .pathMetrics(pathMetrics),
      .acsValid(acsValid), .writeReq(writeReq),
      .writeAddr(writeAddr), .writeData(writeData)
   );

   bestStateFinder best0 (
      .clk(clk), .reset(reset), .acsValid(acsValid),
      .pathMetrics(pathMetrics), .bestValid(bestValid),
      .bestState(bestState), .bestMetric(bestMetric)
   );

   // the writer always wins, its grant is not needed upstream
   memoryArbiter arb0 (
      .clk(clk), .reset(reset),
      .writeReq(writeReq), .readReq(readReq),
      .writeAddr(writeAddr), .readAddr(readAddr), .writeData(writeData),
      .writeGrant(), .readGrant(readGrant),
      .memWrite(memWrite), .memAddr(memAddr), .memWriteData(memWriteData)
   );

   survivorMemory #(.dataWidth(trellisPkg::numStates)) mem0 (
      .clk(clk), .memWrite(memWrite), .memAddr(memAddr),
      .memWriteData(memWriteData), .memReadData(memReadData)
   );

   // writeAddr holds the newest survivor entry
   traceBackUnit tbu0 (
      .clk(clk), .reset(reset), .bestValid(bestValid),
      .bestState(bestState), .headAddr(writeAddr),
      .readGrant(readGrant), .memReadData(memReadData),
      .readReq(readReq), .readAddr(readAddr),
      .decisionValid(decisionValid), .decision(decision)
   );

endmodule

// ==== tbViterbi.sv ====
// testbench of the 20-state Viterbi detector
// drives random branch metrics from an LFSR and checks the best state,
// the best metric and the traceback decisions against a reference model
module tbViterbi;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int numSymbols  = 300;
   localparam int resetCycles = 8;
   localparam int cycleLimit  = 40 * (numSymbols + 4);
   // phases of saturating branches and of tied branches
   localparam int satFirst    = 201;
   localparam int satLast     = 220;
   localparam int tieFirst    = 221;
   localparam int tieLast     = 260;
   localparam int depth       = survivorPkg::tracebackDepth;

   logic                                                    clk;
   logic                                                    reset;
   logic                                                    symEn;
   logic [trellisPkg::numStates*trellisPkg::branchWidth-1:0] zeroMetrics;
   logic [trellisPkg::numStates*trellisPkg::branchWidth-1:0] oneMetrics;
   logic                                                    bestValid;
   logic [trellisPkg::stateWidth-1:0]                       bestState;
   logic [trellisPkg::pathWidth-1:0]                        bestMetric;
   logic                                                    decisionValid;
   logic                                                    decision;

   // reference model state
   logic [15:0]                      lfsr;
   int                               zeroBr [trellisPkg::numStates];
   int                               oneBr  [trellisPkg::numStates];
   int                               modelMetric [trellisPkg::numStates];
   int                               modelBest;
   int                               modelBestState;
   logic [trellisPkg::numStates-1:0] history [$];
   logic                             decisionQueue [$];
   logic                             bestDue;
   int                               decisionCount;
   int                               cycleCount = 0;

   viterbiDecoder dut0 (
      .clk(clk), .reset(reset), .symEn(symEn),
      .zeroMetrics(zeroMetrics), .oneMetrics(oneMetrics),
      .bestValid(bestValid), .bestState(bestState), .bestMetric(bestMetric),
      .decisionValid(decisionValid), .decision(decision)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         $display("timeout: the run did not finish within %0d cycles", cycleLimit);
         $display(">>> FAIL");
         $fatal(1, "timeout");
      end
   end

   // ----------------------------------------
   // checks and random bits
   // ----------------------------------------
   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] want);
      if (got !== want) begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, want);
         $display(">>> FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic abortRun(input string reason);
      $display("error: %s", reason);
      $display(">>> FAIL");
      $fatal(1, "%s", reason);
   endtask

   // 16-bit Galois LFSR with taps 16 14 13 11
   function automatic logic [15:0] galoisStep(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end else begin
         return s >> 1;
      end
   endfunction

   task automatic drawBits(input int count, output int value);
      int i;
      value = 0;
      for (i = 0; i < count; i++) begin
         value = (value << 1) | int'(lfsr[0]);
         lfsr  = galoisStep(lfsr);
      end
   endtask

   // ----------------------------------------
   // stimulus and reference model
   // ----------------------------------------
   task automatic chooseMetrics(input int sym);
      int s;
      int byteVal;
      if (sym >= tieFirst && sym <= tieLast) begin
         // one value everywhere, so the metrics even out and compares tie
         drawBits(8, byteVal);
      end
      for (s = 0; s < trellisPkg::numStates; s++) begin
         if (sym >= satFirst && sym <= satLast) begin
            // state plus symbol parity never changes along a path, so the half
            // fed full scale climbs into saturation while the other stays low
            zeroBr[s] = ((s + sym) % 2 == 0) ? 255 : 0;
            oneBr[s]  = zeroBr[s];
         end else if (sym >= tieFirst && sym <= tieLast) begin
            zeroBr[s] = byteVal;
            oneBr[s]  = byteVal;
         end else begin
            drawBits(8, zeroBr[s]);
            drawBits(8, oneBr[s]);
         end
         zeroMetrics[s*trellisPkg::branchWidth +: trellisPkg::branchWidth] = zeroBr[s];
         oneMetrics[s*trellisPkg::branchWidth +: trellisPkg::branchWidth]  = oneBr[s];
      end
   endtask

   task automatic modelSymbol();
      int                               nextMetric [trellisPkg::numStates];
      logic [trellisPkg::numStates-1:0] surv;
      int                               j;
      int                               i;
      int                               n;
      int                               s;
      int                               a;
      int                               b;
      int                               zs;
      int                               os;
      logic                             bitVal;
      for (j = 0; j < trellisPkg::numStates; j++) begin
         zs = (j + 13) % trellisPkg::numStates;
         os = (j + 7) % trellisPkg::numStates;
         a  = modelMetric[zs] + zeroBr[zs];
         b  = modelMetric[os] + oneBr[os];
         // a tie keeps the zero branch
         surv[j]       = (b < a);
         nextMetric[j] = ((b < a) ? b : a) - modelBest;
         if (nextMetric[j] > 4095) begin
            nextMetric[j] = 4095;
         end
      end
      modelBest      = nextMetric[0];
      modelBestState = 0;
      for (j = 0; j < trellisPkg::numStates; j++) begin
         modelMetric[j] = nextMetric[j];
         if (nextMetric[j] < modelBest) begin
            modelBest      = nextMetric[j];
            modelBestState = j;
         end
      end
      history.push_back(surv);
      n = history.size();
      if (n >= depth) begin
         s = modelBestState;
         for (i = n - 1; i >= n - depth; i--) begin
            bitVal = history[i][s];
            if (i > n - depth) begin
               s = (s + (bitVal ? 7 : 13)) % trellisPkg::numStates;
            end
         end
         decisionQueue.push_back(bitVal);
      end
   endtask

   // one clock with outputs sampled after the edge has settled
   task automatic advance();
      logic want;
      @(posedge clk);
      #2;
      checkValue("bestValid", bestValid, bestDue);
      if (bestValid) begin
         checkValue("bestState", bestState, modelBestState);
         checkValue("bestMetric", bestMetric, modelBest);
      end
      if (decisionValid !== 1'b0) begin
         if (decisionQueue.size() == 0) begin
            abortRun("a decision came out while no symbol was waiting for one");
         end else begin
            checkValue("decisionValid", decisionValid, 1'b1);
            want = decisionQueue.pop_front();
            checkValue("decision", decision, want);
            decisionCount++;
         end
      end
      bestDue = symEn;
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      int sym;
      int gap;
      int s;
      reset         = 1'b1;
      symEn         = 1'b0;
      zeroMetrics   = '0;
      oneMetrics    = '0;
      lfsr          = 16'd3761;
      bestDue       = 1'b0;
      decisionCount = 0;
      modelBest     = 0;
      modelBestState = 0;
      for (s = 0; s < trellisPkg::numStates; s++) begin
         modelMetric[s] = 0;
      end

      repeat (resetCycles) advance();
      reset = 1'b0;
      repeat (2) advance();

      for (sym = 1; sym <= numSymbols; sym++) begin
         if (sym > 1) begin
            checkValue("decisionCount", decisionCount, (sym - 1 >= depth) ? 1 : 0);
         end
         chooseMetrics(sym);
         modelSymbol();
         symEn         = 1'b1;
         decisionCount = 0;
         advance();
         symEn = 1'b0;
         // next strobe 24 to 31 cycles later
         drawBits(3, gap);
         repeat (23 + gap) advance();
      end

      checkValue("decisionCount", decisionCount, 1);
      $display(">>> PASS");
      $finish;
   end

endmodule

// ==== viterbiDecoder.f ====
trellisPkg.sv
survivorPkg.sv
acsArray.sv
bestStateFinder.sv
memoryArbiter.sv
survivorMemory.sv
traceBackUnit.sv
viterbiDecoder.sv
tbViterbi.sv

// ==== runSim.sh ====
#!/bin/bash
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tbViterbi -f viterbiDecoder.f -o simv \
   && ./obj_dir/simv > sim.log 2>&1 \
   || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx ">>> PASS" sim.log && echo "result: passed" \
   || { echo "result: failed"; exit 1; }
